/* src/gba_video_pkg.sv */
// ====================
// GBA video package
// Raster constants, data widths and the packed
// structs shared by the video output path
// ====================

package gba_video_pkg;

	// ====================
	// Types
	// ====================

	typedef logic [14:0] rgb555_t;     // Stored pixel, red in [14:10]
	typedef logic [15:0] fb_addr_t;    // Frame-buffer word address
	typedef logic [8:0]  hcount_t;     // Slot within a line
	typedef logic [8:0]  vcount_t;     // Line within a frame
	typedef logic [7:0]  chan8_t;      // One expanded colour channel
	typedef logic [1:0]  desat_mode_t; // 0 is off, 3 is the strongest

	// Single-cycle write strobe from the core
	typedef struct packed {
		fb_addr_t addr;
		rgb555_t  data;
		logic     we;
	} pixel_write_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hbl;
		logic vbl;
	} video_sync_t;

	typedef struct packed {
		chan8_t r;
		chan8_t g;
		chan8_t b;
	} rgb888_t;

	// ====================
	// Raster
	// ====================

	localparam hcount_t H_TOTAL  = 9'd399; // Slots per line
	localparam hcount_t H_ACTIVE = 9'd240; // hbl rises here
	localparam hcount_t HS_START = 9'd293;
	localparam hcount_t HS_WIDTH = 9'd32;

	localparam vcount_t V_TOTAL  = 9'd264;
	localparam vcount_t V_START  = 9'd62;  // First visible line
	localparam vcount_t V_ACTIVE = 9'd160;
	localparam vcount_t VS_START = 9'd1;
	localparam vcount_t VS_END   = 9'd4;

	// Derived positions
	localparam hcount_t H_LAST   = H_TOTAL - 9'd1;
	localparam hcount_t HS_END   = HS_START + HS_WIDTH;
	localparam vcount_t V_LAST   = V_TOTAL - 9'd1;
	localparam vcount_t V_BLANK  = V_START + V_ACTIVE; // vbl set from here on

	// ====================
	// Pixel clock and memory
	// ====================

	localparam int       CE_DIV   = 8;            // Clocks per pixel slot
	localparam fb_addr_t FB_DEPTH = 16'd38400;    // 240 x 160 words
	localparam fb_addr_t FB_LAST  = FB_DEPTH - 16'd1;

endpackage

/* src/video_timing.sv */
// ====================
// Video scan timing
// Divides clk_sys into pixel slots, runs the 399 x 264 raster,
// makes blank and sync flags and the frame-buffer read address
// ====================

`timescale 1ns/1ps

module video_timing (
	input  logic                      clk_sys,
	input  logic                      reset,
	output logic                      pix_load,
	output logic                      ce_pix,
	output gba_video_pkg::video_sync_t sync,
	output gba_video_pkg::fb_addr_t    rd_addr
);

	import gba_video_pkg::*;

	logic [$clog2(CE_DIV)-1:0] div;  // Free-running slot divider
	hcount_t                   x;
	vcount_t                   y;

	// One clock ahead of ce_pix, lets the colour stage latch the pixel
	assign pix_load = (div == '0);

	// ====================
	// Divider and flags
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div      <= '0;
			ce_pix   <= 1'b0;
			sync.hs  <= 1'b0;
			sync.vs  <= 1'b0;
			sync.hbl <= 1'b0;
			sync.vbl <= 1'b1;   // Raster starts in the top blank
		end else begin
			div    <= div + 1'b1;
			ce_pix <= pix_load;

			// Flags take the value for slot x on the edge that raises ce_pix
			if (pix_load) begin
				if (x == H_ACTIVE)
					sync.hbl <= 1'b1;
				if (x == '0)
					sync.hbl <= 1'b0;

				if (x == HS_START) begin
					sync.hs <= 1'b1;
					// vsync edges are aligned to the hsync slot
					if (y == VS_START)
						sync.vs <= 1'b1;
					if (y == VS_END)
						sync.vs <= 1'b0;
				end
				if (x == HS_END)
					sync.hs <= 1'b0;

				if (y == V_START)
					sync.vbl <= 1'b0;
				if (y >= V_BLANK)
					sync.vbl <= 1'b1;
			end
		end
	end

	// ====================
	// Raster counters
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (ce_pix) begin
			if (x == H_LAST) begin
				x <= '0;
				if (y == V_LAST)
					y <= '0;      // Free running, no resync to the core
				else
					y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// ====================
	// Read address
	// ====================

	// Moves only on ce_pix, so it is stable for 7 clocks before the
	// next pix_load and the registered RAM output is ready in time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_addr <= '0;
		end else if (ce_pix) begin
			if (sync.vbl) begin
				rd_addr <= '0;
			end else if (!sync.hbl) begin
				// Wrap after the last word, vblank rewinds it anyway
				if (rd_addr == FB_LAST)
					rd_addr <= '0;
				else
					rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	// ====================
	// Checks
	// ====================

	a_ce_single : assert property (
		@(posedge clk_sys) disable iff (reset)
		ce_pix |=> !ce_pix
	) else $error("ce_pix high in two consecutive clocks");

	a_rd_range : assert property (
		@(posedge clk_sys) disable iff (reset)
		rd_addr < FB_DEPTH
	) else $error("rd_addr %0d out of frame buffer", rd_addr);

endmodule

/* src/frame_buffer.sv */
// ====================
// Frame buffer
// 240 x 160 RGB555 words, one write port from the core
// and one registered read port for the scan-out
// ====================

`timescale 1ns/1ps

module frame_buffer (
	input  logic                       clk_sys,
	input  gba_video_pkg::pixel_write_t wr,
	input  gba_video_pkg::fb_addr_t     rd_addr,
	output gba_video_pkg::rgb555_t      rd_data
);

	import gba_video_pkg::*;

	rgb555_t mem [0:FB_LAST];

	// Write side, single-cycle strobe, never stalls
	always_ff @(posedge clk_sys) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;
	end

	// Read side, data one clock after the address
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

	// The core addresses words 0 to 38399 only
	a_wr_range : assert property (
		@(posedge clk_sys)
		wr.we |-> (wr.addr < FB_DEPTH)
	) else $error("Pixel write at %0d beyond frame buffer", wr.addr);

endmodule

/* src/color_desat.sv */
// ====================
// Colour stage
// Expands RGB555 to RGB888 and blends each channel
// towards luma in one of four levels
// ====================

`timescale 1ns/1ps

module color_desat (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      pix_load,
	input  gba_video_pkg::desat_mode_t mode,
	input  gba_video_pkg::rgb555_t     pixel,
	output gba_video_pkg::rgb888_t     rgb
);

	import gba_video_pkg::*;

	chan8_t  r_in;
	chan8_t  g_in;
	chan8_t  b_in;
	chan8_t  luma;
	rgb888_t rgb_next;

	// Blend one channel with luma, all sums wrap at 8 bits
	function automatic chan8_t desat(input chan8_t c, input chan8_t y, input desat_mode_t m);
		chan8_t res;
		case (m)
			2'd1:    res = (c >> 1) + (c >> 2) + (y >> 2); // 3/4 colour
			2'd2:    res = (c >> 1) + (y >> 1);            // Half and half
			2'd3:    res = (y >> 1) + (y >> 2) + (c >> 2); // 3/4 luma
			default: res = c;
		endcase
		return res;
	endfunction

	// Repeat the top three bits so 5'h1f maps to 8'hff
	assign r_in = {pixel[14:10], pixel[14:12]};
	assign g_in = {pixel[9:5],   pixel[9:7]};
	assign b_in = {pixel[4:0],   pixel[4:2]};

	// Roughly 0.25 R + 0.625 G + 0.125 B
	assign luma = (r_in >> 2) + (g_in >> 1) + (g_in >> 3) + (b_in >> 3);

	always_comb begin
		rgb_next.r = desat(r_in, luma, mode);
		rgb_next.g = desat(g_in, luma, mode);
		rgb_next.b = desat(b_in, luma, mode);
	end

	// ====================
	// Output register
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset)
			rgb <= '0;
		else if (pix_load)
			rgb <= rgb_next;  // Held for the whole slot
	end

endmodule

/* src/gba_video.sv */
// ====================
// GBA video output
// Frame buffer scan-out with raster timing
// and colour expansion
// ====================

`timescale 1ns/1ps

module gba_video (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_video_pkg::pixel_write_t pix_wr,
	input  gba_video_pkg::desat_mode_t  desat_mode,
	output logic                       ce_pix,
	output gba_video_pkg::video_sync_t  sync,
	output gba_video_pkg::rgb888_t      rgb
);

	import gba_video_pkg::*;

	logic     pix_load;   // Clock before each pixel slot
	fb_addr_t rd_addr;
	rgb555_t  rd_data;

	video_timing u_timing (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pix_load (pix_load),
		.ce_pix   (ce_pix),
		.sync     (sync),
		.rd_addr  (rd_addr)
	);

	frame_buffer u_fb (
		.clk_sys (clk_sys),
		.wr      (pix_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Latches rd_data on pix_load, in step with the sync flags
	color_desat u_color (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pix_load (pix_load),
		.mode     (desat_mode),
		.pixel    (rd_data),
		.rgb      (rgb)
	);

endmodule

/* tb/gba_video_checker.sv */
// ====================
// GBA video checker
// Shadows the frame buffer, measures line and frame timing
// and compares every visible pixel with a reference colour
// ====================

`timescale 1ns/1ps

module gba_video_checker (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        done,
	input  gba_video_pkg::pixel_write_t pix_wr,
	input  gba_video_pkg::desat_mode_t  desat_mode,
	input  logic                        ce_pix,
	input  gba_video_pkg::video_sync_t  sync,
	input  gba_video_pkg::rgb888_t      rgb,
	output int                          tests_run,
	output int                          fail_count
);

	import gba_video_pkg::*;

	localparam int WORDS = 240 * 160;

	rgb555_t shadow [0:WORDS-1];   // What the core has written so far
	int      n_tests = 0;
	int      n_failed = 0;
	int      reset_errs = 0;
	int      cadence_errs = 0;
	int      since_ce = 0;
	int      slots = 0;
	int      hbl_slots = 0;
	int      hbl_runs = 0;
	int      hs_slots = 0;
	int      hs_runs = 0;
	int      lines = 0;
	int      vis_lines = 0;
	int      vs_slots = 0;
	int      vs_runs = 0;
	int      line_errs = 0;
	int      pix_idx = 0;
	int      pix_errs = 0;
	int      frame_no = 0;
	int      frame_mode = 0;
	logic    ce_seen = 1'b0;
	logic    line_open = 1'b0;
	logic    frame_open = 1'b0;
	logic    closed = 1'b0;
	logic    prev_reset = 1'b1;
	logic    prev_hbl = 1'b0;
	logic    prev_vbl = 1'b1;
	logic    prev_hs = 1'b0;
	logic    prev_vs = 1'b0;
	logic    new_line;
	logic    new_frame;
	rgb888_t want;

	assign tests_run  = n_tests;
	assign fail_count = n_failed;

	// ====================
	// Reference colour
	// ====================

	// Top three bits repeated below the five
	function automatic int widen5(input logic [4:0] c);
		return int'(c) * 8 + int'(c) / 4;
	endfunction

	function automatic int blend(input int c, input int luma, input desat_mode_t m);
		case (m)
			2'd1:    return c / 2 + c / 4 + luma / 4;
			2'd2:    return c / 2 + luma / 2;
			2'd3:    return luma / 2 + luma / 4 + c / 4;
			default: return c;
		endcase
	endfunction

	function automatic rgb888_t expected_rgb(input rgb555_t px, input desat_mode_t m);
		int      r;
		int      g;
		int      b;
		int      luma;
		rgb888_t res;
		r = widen5(px[14:10]);
		g = widen5(px[9:5]);
		b = widen5(px[4:0]);
		luma = (r / 4 + g / 2 + g / 8 + b / 8) % 256;
		res.r = chan8_t'(blend(r, luma, m) % 256);
		res.g = chan8_t'(blend(g, luma, m) % 256);
		res.b = chan8_t'(blend(b, luma, m) % 256);
		return res;
	endfunction

	function automatic string pixel_test_name();
		return $sformatf("pixels_frame%0d_mode%0d", frame_no, frame_mode);
	endfunction

	// Returns 1 when a measured count is off, with a MISMATCH line if show is set
	function automatic int count_error(input string name, input int exp_n, input int act_n,
			input logic show);
		if (exp_n == act_n)
			return 0;
		if (show)
			$display("MISMATCH %s: expected %0d actual %0d", name, exp_n, act_n);
		return 1;
	endfunction

	task automatic report_test(input string name, input int errs);
		n_tests++;
		if (errs != 0)
			n_failed++;
		$display("Test %s: %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
	endtask

	// ====================
	// Line and frame ends
	// ====================

	task automatic check_line();
		string name;
		logic  show;
		int    errs;
		name = $sformatf("line_timing_%0d", frame_no);
		show = (line_errs < 4);
		errs = count_error({name, " slots"}, 399, slots, show);
		errs += count_error({name, " hbl slots"}, 159, hbl_slots, show);
		errs += count_error({name, " hbl runs"}, 1, hbl_runs, show);
		errs += count_error({name, " hs slots"}, 32, hs_slots, show);
		errs += count_error({name, " hs runs"}, 1, hs_runs, show);
		if (errs != 0)
			line_errs++;
	endtask

	// Runs on each vbl rise and closes the frame before it
	// The first frame after reset is partial
	task automatic finish_frame();
		string name;
		int    errs;
		if (frame_open) begin
			name = $sformatf("frame_timing_%0d", frame_no);
			errs = count_error({name, " lines"}, 264, lines, 1'b1);
			errs += count_error({name, " visible lines"}, 160, vis_lines, 1'b1);
			errs += count_error({name, " vs slots"}, 3 * 399, vs_slots, 1'b1);
			errs += count_error({name, " vs runs"}, 1, vs_runs, 1'b1);
			errs += count_error({name, " pixels"}, WORDS, pix_idx, 1'b1);
			report_test(name, errs);
		end
		report_test($sformatf("line_timing_%0d", frame_no), line_errs);
		report_test(pixel_test_name(), pix_errs);
		frame_open = 1'b1;
		frame_no++;
		lines = 0;
		vis_lines = 0;
		vs_slots = 0;
		vs_runs = 0;
		line_errs = 0;
		pix_idx = 0;
		pix_errs = 0;
	endtask

	task automatic check_slot();
		new_line  = prev_hbl && !sync.hbl;
		new_frame = !prev_vbl && sync.vbl;
		if (new_line && line_open)
			check_line();
		if (new_frame)
			finish_frame();
		if (new_line) begin
			slots = 0;
			hbl_slots = 0;
			hbl_runs = 0;
			hs_slots = 0;
			hs_runs = 0;
			line_open = 1'b1;
			lines++;
			if (!sync.vbl)
				vis_lines++;
		end
		slots++;
		hbl_slots += sync.hbl ? 1 : 0;
		hbl_runs  += (sync.hbl && !prev_hbl) ? 1 : 0;
		hs_slots  += sync.hs ? 1 : 0;
		hs_runs   += (sync.hs && !prev_hs) ? 1 : 0;
		vs_slots  += sync.vs ? 1 : 0;
		vs_runs   += (sync.vs && !prev_vs) ? 1 : 0;

		if (!sync.hbl && !sync.vbl) begin
			if (pix_idx == 0)
				frame_mode = int'(desat_mode);
			if (pix_idx < WORDS) begin
				want = expected_rgb(shadow[fb_addr_t'(pix_idx)], desat_mode);
				if (rgb != want) begin
					pix_errs++;
					if (pix_errs <= 8)
						$display("MISMATCH %s word %0d: expected %06h actual %06h",
							pixel_test_name(), pix_idx, want, rgb);
				end
			end
			pix_idx++;
		end
		prev_hbl = sync.hbl;
		prev_vbl = sync.vbl;
		prev_hs  = sync.hs;
		prev_vs  = sync.vs;
	endtask

	// ====================
	// Sampling
	// ====================

	// Sampled on the falling edge, halfway between DUT updates
	always @(negedge clk_sys) begin
		if (pix_wr.we && int'(pix_wr.addr) < WORDS)
			shadow[pix_wr.addr] = pix_wr.data;

		if (reset) begin
			if (ce_pix || sync.hs || sync.vs || sync.hbl || !sync.vbl || rgb != '0) begin
				reset_errs++;
				$display("Outputs are not at their reset values while reset is high");
			end
		end else begin
			if (prev_reset)
				report_test("reset_values", reset_errs);
			if (ce_pix) begin
				if (ce_seen && since_ce != 7) begin
					cadence_errs++;
					$display("ce_pix came %0d clocks after the previous one", since_ce + 1);
				end
				ce_seen = 1'b1;
				since_ce = 0;
				check_slot();
			end else begin
				since_ce++;
				if (ce_seen && since_ce == 8) begin
					cadence_errs++;
					$display("ce_pix missing for 8 clocks");
				end
			end
		end
		prev_reset = reset;

		if (done && !closed) begin
			report_test("ce_pix_cadence", cadence_errs);
			$display("Checks done: %0d tests, %0d passed, %0d failed",
				n_tests, n_tests - n_failed, n_failed);
			closed = 1'b1;
		end
	end

endmodule

/* tb/tb_gba_video.sv */
// ====================
// GBA video testbench
// Loads the frame buffer from an LFSR, steps the desaturation
// mode once per frame and rewrites part of the image
// ====================

`timescale 1ns/1ps

module tb_gba_video;

	import gba_video_pkg::*;

	localparam int LINE_CLKS      = 399 * 8;
	localparam int FRAME_CLKS     = 264 * LINE_CLKS;   // 842688 clocks
	// Load frame plus five more, up to the end of the last visible line
	localparam int RUN_CLKS       = 5 * FRAME_CLKS + 222 * LINE_CLKS;
	localparam int TIMEOUT_CLKS   = RUN_CLKS + 24 * LINE_CLKS;  // Close to 5M
	localparam int WORDS          = 240 * 160;
	localparam int REWRITE_WORDS  = 4800;
	localparam int EXPECTED_TESTS = 19;

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         done;
	pixel_write_t pix_wr;
	desat_mode_t  desat_mode;
	logic         ce_pix;
	video_sync_t  sync;
	rgb888_t      rgb;
	int           tests_run;
	int           fail_count;
	int           cycle_count = 0;
	logic [31:0]  lfsr;

	always #50 clk_sys = ~clk_sys;   // 100 ns period

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_pixel(output rgb555_t px);
		px = '0;
		for (int i = 0; i < 15; i++) begin
			lfsr = lfsr_next(lfsr);
			px = {px[13:0], lfsr[0]};   // One step per bit
		end
	endtask

	// One write strobe per clock from word 0 up
	task automatic write_words(input int count);
		rgb555_t px;
		for (int a = 0; a < count; a++) begin
			draw_pixel(px);
			pix_wr.addr <= fb_addr_t'(a);
			pix_wr.data <= px;
			pix_wr.we   <= 1'b1;
			@(posedge clk_sys);
		end
		pix_wr.we <= 1'b0;
	endtask

	task automatic wait_vbl_rise();
		@(posedge clk_sys);
		while (sync.vbl)
			@(posedge clk_sys);
		while (!sync.vbl)
			@(posedge clk_sys);
	endtask

	// vsync rises on line 1, inside the next frame's top blank
	task automatic wait_vs();
		while (!sync.vs)
			@(posedge clk_sys);
	endtask

	initial begin
		reset      = 1'b1;
		done       = 1'b0;
		pix_wr     = '0;
		desat_mode = '0;
		lfsr       = 32'h0f3d_a54d;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		write_words(WORDS);
		wait_vbl_rise();
		for (int frame = 1; frame <= 5; frame++) begin
			desat_mode <= desat_mode_t'((frame - 1) % 4);   // 0, 1, 2, 3, then 0
			if (frame == 5) begin
				wait_vs();
				write_words(REWRITE_WORDS);
			end
			wait_vbl_rise();
		end
		done <= 1'b1;
		repeat (2) @(posedge clk_sys);
		if (fail_count == 0 && tests_run == EXPECTED_TESTS) begin
			$display("Simulation PASSED");
		end else begin
			if (tests_run != EXPECTED_TESTS)
				$display("Only %0d of %0d tests were reported", tests_run, EXPECTED_TESTS);
			$display("Simulation FAILED");
		end
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CLKS) begin
			$display("Timeout: run still going after %0d clocks", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	gba_video dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pix_wr     (pix_wr),
		.desat_mode (desat_mode),
		.ce_pix     (ce_pix),
		.sync       (sync),
		.rgb        (rgb)
	);

	gba_video_checker u_check (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.done       (done),
		.pix_wr     (pix_wr),
		.desat_mode (desat_mode),
		.ce_pix     (ce_pix),
		.sync       (sync),
		.rgb        (rgb),
		.tests_run  (tests_run),
		.fail_count (fail_count)
	);

endmodule

/* gba_video.f */
src/gba_video_pkg.sv
src/video_timing.sv
src/frame_buffer.sv
src/color_desat.sv
src/gba_video.sv
tb/gba_video_checker.sv
tb/tb_gba_video.sv

/* run_sim.sh */
#!/bin/sh
# Build the GBA video testbench with Verilator, run it and scan the log

verilator --binary --timing --assert --top-module tb_gba_video \
	-f gba_video.f -o sim_gba_video > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_gba_video > sim.log 2>&1 \
	|| echo "Simulator exited with a non-zero status" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "non-zero status" sim.log && exit 1
exit 0
